/* filelist.f */
+incdir+bench
hw/axi_proto_pkg.sv
hw/slice_cfg_pkg.sv
hw/axi_ar_if.sv
hw/axi_r_if.sv
hw/axi_ar_slice.sv
hw/axi_r_slice.sv
hw/axi_read_register.sv
bench/tb_clock.sv
bench/tb_axi_read_register.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI read register testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
      -f filelist.f --top-module tb_axi_read_register -Mdir obj_dir; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_axi_read_register)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
   exit 0
fi
exit 1

/* bench/tb_checks.svh */
/*
 * Testbench check helpers
 * Expected beat records, compare tasks per result kind, error counters
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One read-address beat as seen on either side of the slice
typedef struct packed {
   logic [slice_cfg_pkg::DEF_ID_W-1:0]   id;
   logic [slice_cfg_pkg::DEF_ADDR_W-1:0] addr;
   axi_proto_pkg::axi_len_t              len;
   axi_proto_pkg::axi_size_t             size;
   axi_proto_pkg::axi_burst_e            burst;
   logic                                 lock;
   axi_proto_pkg::axi_cache_t            cache;
   axi_proto_pkg::axi_prot_t             prot;
   axi_proto_pkg::axi_qos_t              qos;
   axi_proto_pkg::axi_region_t           region;
} ar_beat_t;

// One read-data beat, last rides along as payload
typedef struct packed {
   logic [slice_cfg_pkg::DEF_ID_W-1:0]   id;
   logic [slice_cfg_pkg::DEF_DATA_W-1:0] data;
   axi_proto_pkg::axi_resp_e             resp;
   logic                                 last;
} r_beat_t;

int error_count = 0;
int check_count = 0;

task automatic compare_ar(input ar_beat_t got, input ar_beat_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: AR beat, burst %s vs %s, got %h, expected %h", $time,
               got.burst.name(), exp.burst.name(), got, exp);
   end
endtask

task automatic compare_r(input r_beat_t got, input r_beat_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: R beat, resp %s vs %s, last %b vs %b, got %h, expected %h",
               $time, got.resp.name(), exp.resp.name(), got.last, exp.last, got, exp);
   end
endtask

// Counts and single flags
task automatic compare_int(input string what, input int got, input int exp);
   check_count++;
   if (got != exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
   end
endtask

// Protocol problems that are not a wrong value
task automatic note_failure(input string msg);
   error_count++;
   $display("Error at %0t ns: %s", $time, msg);
endtask

`endif

/* bench/tb_axi_read_register.sv */
/*
 * Testbench for the AXI read register slice
 * Directed tests on AR (simple mode) and R (skid mode), output monitor, watchdog
 */
`timescale 1ns/100ps

module tb_axi_read_register;

   localparam int ID_W   = slice_cfg_pkg::DEF_ID_W;
   localparam int ADDR_W = slice_cfg_pkg::DEF_ADDR_W;
   localparam int DATA_W = slice_cfg_pkg::DEF_DATA_W;
   // 20 cycles per planned beat, plus reset and idle checks
   localparam int PLANNED_BEATS = 85;
   localparam int TIMEOUT_NS    = (PLANNED_BEATS * 20 + 40) * 8;

   logic clk;
   logic rst_n;
   logic s_arvalid, s_arready, s_arlock, m_arvalid, m_arready, m_arlock;
   logic [ID_W-1:0] s_arid, m_arid, s_rid, m_rid;
   logic [ADDR_W-1:0] s_araddr, m_araddr;
   axi_proto_pkg::axi_len_t s_arlen, m_arlen;
   axi_proto_pkg::axi_size_t s_arsize, m_arsize;
   axi_proto_pkg::axi_burst_e s_arburst, m_arburst;
   axi_proto_pkg::axi_cache_t s_arcache, m_arcache;
   axi_proto_pkg::axi_prot_t s_arprot, m_arprot;
   axi_proto_pkg::axi_qos_t s_arqos, m_arqos;
   axi_proto_pkg::axi_region_t s_arregion, m_arregion;
   logic s_rvalid, s_rready, s_rlast, m_rvalid, m_rready, m_rlast;
   logic [DATA_W-1:0] s_rdata, m_rdata;
   axi_proto_pkg::axi_resp_e s_rresp, m_rresp;

   `include "tb_checks.svh"

   // Expected beats in order, popped by the monitor
   ar_beat_t ar_exp_q[$];
   r_beat_t  r_exp_q[$];
   int       ar_seen = 0;
   int       r_seen = 0;

   tb_clock #(.HALF_NS(4), .RST_CYCLES(5)) u_clock (.clk(clk), .rst_n(rst_n));

   axi_read_register #(
      .ID_W(ID_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W),
      .AR_MODE(slice_cfg_pkg::SLICE_SIMPLE), .R_MODE(slice_cfg_pkg::SLICE_SKID)
   ) dut0 (.*);

   function automatic ar_beat_t rand_ar();
      ar_beat_t b;
      b.id     = ID_W'($urandom);
      b.addr   = ADDR_W'($urandom);
      b.len    = 8'($urandom);
      b.size   = 3'($urandom);
      b.burst  = axi_proto_pkg::axi_burst_e'(2'($urandom_range(0, 2)));
      b.lock   = 1'($urandom);
      b.cache  = 4'($urandom);
      b.prot   = 3'($urandom);
      b.qos    = 4'($urandom);
      b.region = 4'($urandom);
      return b;
   endfunction

   function automatic r_beat_t rand_r(input logic last);
      r_beat_t b;
      b.id   = ID_W'($urandom);
      b.data = DATA_W'({$urandom, $urandom});
      b.resp = axi_proto_pkg::axi_resp_e'(2'($urandom));
      b.last = last;
      return b;
   endfunction

   // --------------------------------------------------
   // Source drivers, called on a falling edge
   // --------------------------------------------------
   // Valid and payload held until the accepting edge
   task automatic send_ar(input ar_beat_t b);
      {s_arid, s_araddr, s_arlen, s_arsize, s_arburst, s_arlock} =
         {b.id, b.addr, b.len, b.size, b.burst, b.lock};
      {s_arcache, s_arprot, s_arqos, s_arregion} = {b.cache, b.prot, b.qos, b.region};
      s_arvalid = 1'b1;
      ar_exp_q.push_back(b);
      do @(posedge clk); while (!s_arready);
      @(negedge clk);
      s_arvalid = 1'b0;
   endtask

   task automatic send_r(input r_beat_t b);
      {m_rid, m_rdata, m_rresp, m_rlast} = {b.id, b.data, b.resp, b.last};
      m_rvalid = 1'b1;
      r_exp_q.push_back(b);
      do @(posedge clk); while (!m_rready);
      @(negedge clk);
      m_rvalid = 1'b0;
   endtask

   task automatic wait_drained();
      do @(negedge clk); while (ar_exp_q.size() != 0 || r_exp_q.size() != 0);
   endtask

   task automatic report_test(input string name, input int err0);
      if (error_count == err0) $display("test %s: passed", name);
      else $display("test %s: failed with %0d errors", name, error_count - err0);
   endtask

   // Checks every output transfer against the head of its queue
   task automatic monitor_outputs();
      logic ar_in_prev;
      logic ar_in_now;
      ar_in_prev = 1'b0;
      forever begin
         @(posedge clk);
         ar_in_now = rst_n && s_arvalid && s_arready;
         // Simple mode leaves a bubble after each accepted address
         if (ar_in_now && ar_in_prev) note_failure("AR input accepted in two cycles in a row");
         ar_in_prev = ar_in_now;
         if (rst_n && m_arvalid && m_arready) begin
            ar_seen++;
            if (ar_exp_q.size() == 0) note_failure("AR beat left the slice with none pending");
            else compare_ar('{m_arid, m_araddr, m_arlen, m_arsize, m_arburst, m_arlock,
                              m_arcache, m_arprot, m_arqos, m_arregion}, ar_exp_q.pop_front());
         end
         if (rst_n && s_rvalid && s_rready) begin
            r_seen++;
            if (r_exp_q.size() == 0) note_failure("R beat left the slice with none pending");
            else compare_r('{s_rid, s_rdata, s_rresp, s_rlast}, r_exp_q.pop_front());
         end
      end
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_reset_idle();
      int err0;
      err0 = error_count;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         compare_int("m_arvalid while idle", int'(m_arvalid), 0);
         compare_int("s_rvalid while idle", int'(s_rvalid), 0);
         // Both inputs open within two edges of reset release
         if (i >= 1) compare_int("s_arready after reset", int'(s_arready), 1);
         if (i >= 1) compare_int("m_rready after reset", int'(m_rready), 1);
      end
      report_test("reset_idle", err0);
   endtask

   task automatic test_ar_stream();
      int err0;
      int seen0;
      err0 = error_count;
      seen0 = ar_seen;
      m_arready = 1'b1;
      for (int i = 0; i < 20; i++) send_ar(rand_ar());
      wait_drained();
      compare_int("AR beats delivered", ar_seen - seen0, 20);
      report_test("ar_stream", err0);
   endtask

   task automatic test_ar_backpressure();
      int err0;
      int seen0;
      err0 = error_count;
      seen0 = ar_seen;
      m_arready = 1'b0;
      fork
         for (int i = 0; i < 4; i++) send_ar(rand_ar());
         begin
            do @(posedge clk); while (!(s_arvalid && s_arready));
            repeat (6) begin
               @(posedge clk);
               if (s_arready) note_failure("s_arready rose while the AR output was stalled");
            end
            @(negedge clk);
            m_arready = 1'b1;
         end
      join
      wait_drained();
      compare_int("AR beats after stall", ar_seen - seen0, 4);
      report_test("ar_backpressure", err0);
   endtask

   task automatic test_r_random();
      int err0;
      int seen0;
      bit src_done;
      err0 = error_count;
      seen0 = r_seen;
      src_done = 1'b0;
      fork
         begin
            for (int i = 0; i < 30; i++) begin
               repeat ($urandom_range(0, 1)) @(negedge clk);
               send_r(rand_r(i % 4 == 3 || i == 29));
            end
            src_done = 1'b1;
         end
         while (!src_done) begin
            @(negedge clk);
            s_rready = 1'($urandom);
         end
      join
      s_rready = 1'b1;
      wait_drained();
      compare_int("R beats delivered", r_seen - seen0, 30);
      report_test("r_random", err0);
   endtask

   task automatic test_r_throughput();
      int err0;
      int count;
      err0 = error_count;
      count = 0;
      s_rready = 1'b1;
      fork
         for (int i = 0; i < 16; i++) send_r(rand_r(i == 15));
         begin
            do @(posedge clk); while (!(m_rvalid && m_rready));
            count = 1;
            while (count < 16) begin
               @(posedge clk);
               if (m_rvalid && m_rready) count++;
               else note_failure("R input stalled during a full-rate stream");
            end
         end
      join
      wait_drained();
      report_test("r_throughput", err0);
   endtask

   task automatic test_independence();
      int err0;
      int ar0;
      err0 = error_count;
      ar0 = ar_seen;
      m_arready = 1'b0;
      s_rready = 1'b1;
      fork
         for (int i = 0; i < 3; i++) send_ar(rand_ar());
         begin
            for (int i = 0; i < 12; i++) send_r(rand_r(i == 11));
            while (r_exp_q.size() != 0) @(negedge clk);
            // First address beat still waits at the stalled output
            compare_int("m_arvalid during R burst", int'(m_arvalid), 1);
            m_arready = 1'b1;
         end
      join
      wait_drained();
      compare_int("AR beats after release", ar_seen - ar0, 3);
      report_test("independence", err0);
   endtask

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'hb65df6f0));
      {s_arvalid, s_arid, s_araddr, s_arlen, s_arsize, s_arlock} = '0;
      {s_arcache, s_arprot, s_arqos, s_arregion} = '0;
      s_arburst = axi_proto_pkg::FIXED;
      {m_rvalid, m_rid, m_rdata, m_rlast} = '0;
      m_rresp = axi_proto_pkg::OKAY;
      m_arready = 1'b0;
      s_rready = 1'b0;
      fork
         monitor_outputs();
      join_none
      wait (rst_n === 1'b1);
      test_reset_idle();
      test_ar_stream();
      test_ar_backpressure();
      test_r_random();
      test_r_throughput();
      test_independence();
      $display("Checks: %0d, errors: %0d, AR beats: %0d, R beats: %0d",
               check_count, error_count, ar_seen, r_seen);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* bench/tb_clock.sv */
/*
 * Testbench clock and reset source
 * Free-running clock, active-low reset held for a set number of cycles
 */
`timescale 1ns/100ps

module tb_clock #(
   parameter int HALF_NS    = 4,
   parameter int RST_CYCLES = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* hw/axi_read_register.sv */
/*
 * AXI read channel register slice, top level
 * Plain AXI ports bound to channel bundles, one AR and one R slice
 */
`timescale 1ns/100ps

module axi_read_register #(
   parameter int ID_W   = slice_cfg_pkg::DEF_ID_W,
   parameter int ADDR_W = slice_cfg_pkg::DEF_ADDR_W,
   parameter int DATA_W = slice_cfg_pkg::DEF_DATA_W,
   parameter slice_cfg_pkg::slice_mode_e AR_MODE = slice_cfg_pkg::SLICE_SIMPLE,
   parameter slice_cfg_pkg::slice_mode_e R_MODE  = slice_cfg_pkg::SLICE_SKID
) (
   input  logic                       clk,
   input  logic                       rst_n,
   // Slave side, read address
   input  logic                       s_arvalid,
   output logic                       s_arready,
   input  logic [ID_W-1:0]            s_arid,
   input  logic [ADDR_W-1:0]          s_araddr,
   input  axi_proto_pkg::axi_len_t    s_arlen,
   input  axi_proto_pkg::axi_size_t   s_arsize,
   input  axi_proto_pkg::axi_burst_e  s_arburst,
   input  logic                       s_arlock,
   input  axi_proto_pkg::axi_cache_t  s_arcache,
   input  axi_proto_pkg::axi_prot_t   s_arprot,
   input  axi_proto_pkg::axi_qos_t    s_arqos,
   input  axi_proto_pkg::axi_region_t s_arregion,
   // Slave side, read data
   output logic                       s_rvalid,
   input  logic                       s_rready,
   output logic [ID_W-1:0]            s_rid,
   output logic [DATA_W-1:0]          s_rdata,
   output axi_proto_pkg::axi_resp_e   s_rresp,
   output logic                       s_rlast,
   // Master side, read address
   output logic                       m_arvalid,
   input  logic                       m_arready,
   output logic [ID_W-1:0]            m_arid,
   output logic [ADDR_W-1:0]          m_araddr,
   output axi_proto_pkg::axi_len_t    m_arlen,
   output axi_proto_pkg::axi_size_t   m_arsize,
   output axi_proto_pkg::axi_burst_e  m_arburst,
   output logic                       m_arlock,
   output axi_proto_pkg::axi_cache_t  m_arcache,
   output axi_proto_pkg::axi_prot_t   m_arprot,
   output axi_proto_pkg::axi_qos_t    m_arqos,
   output axi_proto_pkg::axi_region_t m_arregion,
   // Master side, read data
   input  logic                       m_rvalid,
   output logic                       m_rready,
   input  logic [ID_W-1:0]            m_rid,
   input  logic [DATA_W-1:0]          m_rdata,
   input  axi_proto_pkg::axi_resp_e   m_rresp,
   input  logic                       m_rlast
);

   axi_ar_if #(.ID_W(ID_W), .ADDR_W(ADDR_W)) s_ar ();
   axi_ar_if #(.ID_W(ID_W), .ADDR_W(ADDR_W)) m_ar ();
   axi_r_if  #(.ID_W(ID_W), .DATA_W(DATA_W)) s_r ();
   axi_r_if  #(.ID_W(ID_W), .DATA_W(DATA_W)) m_r ();

   // --------------------------------------------------
   // Address channel, slave to master
   // --------------------------------------------------
   assign s_ar.valid  = s_arvalid;
   assign s_ar.id     = s_arid;
   assign s_ar.addr   = s_araddr;
   assign s_ar.len    = s_arlen;
   assign s_ar.size   = s_arsize;
   assign s_ar.burst  = s_arburst;
   assign s_ar.lock   = s_arlock;
   assign s_ar.cache  = s_arcache;
   assign s_ar.prot   = s_arprot;
   assign s_ar.qos    = s_arqos;
   assign s_ar.region = s_arregion;
   assign s_arready   = s_ar.ready;

   assign m_arvalid   = m_ar.valid;
   assign m_arid      = m_ar.id;
   assign m_araddr    = m_ar.addr;
   assign m_arlen     = m_ar.len;
   assign m_arsize    = m_ar.size;
   assign m_arburst   = m_ar.burst;
   assign m_arlock    = m_ar.lock;
   assign m_arcache   = m_ar.cache;
   assign m_arprot    = m_ar.prot;
   assign m_arqos     = m_ar.qos;
   assign m_arregion  = m_ar.region;
   assign m_ar.ready  = m_arready;

   axi_ar_slice #(.MODE(AR_MODE), .ID_W(ID_W), .ADDR_W(ADDR_W)) u_ar_slice (
      .clk   (clk),
      .rst_n (rst_n),
      .up    (s_ar),
      .down  (m_ar)
   );

   // --------------------------------------------------
   // Data channel, master to slave
   // --------------------------------------------------
   assign m_r.valid = m_rvalid;
   assign m_r.id    = m_rid;
   assign m_r.data  = m_rdata;
   assign m_r.resp  = m_rresp;
   assign m_r.last  = m_rlast;
   assign m_rready  = m_r.ready;

   assign s_rvalid  = s_r.valid;
   assign s_rid     = s_r.id;
   assign s_rdata   = s_r.data;
   assign s_rresp   = s_r.resp;
   assign s_rlast   = s_r.last;
   assign s_r.ready = s_rready;

   axi_r_slice #(.MODE(R_MODE), .ID_W(ID_W), .DATA_W(DATA_W)) u_r_slice (
      .clk   (clk),
      .rst_n (rst_n),
      .up    (m_r),
      .down  (s_r)
   );

endmodule

/* hw/axi_r_slice.sv */
/*
 * Read-data channel register slice
 * Same skid and simple register modes as the address slice
 * last is carried as payload
 */
`timescale 1ns/100ps

module axi_r_slice #(
   parameter slice_cfg_pkg::slice_mode_e MODE = slice_cfg_pkg::SLICE_SKID,
   parameter int ID_W   = slice_cfg_pkg::DEF_ID_W,
   parameter int DATA_W = slice_cfg_pkg::DEF_DATA_W
) (
   input  logic  clk,
   input  logic  rst_n,
   axi_r_if.up   up,
   axi_r_if.down down
);

   typedef struct packed {
      logic [ID_W-1:0]          id;
      logic [DATA_W-1:0]        data;
      axi_proto_pkg::axi_resp_e resp;
      logic                     last;
   } r_beat_t;

   r_beat_t in_beat;
   r_beat_t out_q;
   logic    out_valid_q;
   logic    ready_q;
   logic    up_fire;
   logic    out_load;

   assign in_beat  = '{id: up.id, data: up.data, resp: up.resp, last: up.last};
   assign up_fire  = up.valid && ready_q;
   assign out_load = !out_valid_q || down.ready;

   generate
      if (MODE == slice_cfg_pkg::SLICE_SKID) begin : g_skid
         // --------------------------------------------------
         // Skid buffer
         // --------------------------------------------------
         r_beat_t skid_q;
         logic    use_skid_q;
         logic    use_skid_d;

         always_comb begin
            use_skid_d = use_skid_q;
            if (out_load) begin
               use_skid_d = 1'b0;
            end else if (up_fire) begin
               use_skid_d = 1'b1;
            end
         end

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               out_valid_q <= 1'b0;
               use_skid_q  <= 1'b0;
               ready_q     <= 1'b0;
            end else begin
               use_skid_q <= use_skid_d;
               ready_q    <= !use_skid_d;
               if (out_load) begin
                  out_valid_q <= use_skid_q || up_fire;
               end
            end
         end

         // Held beat has priority over the input on the next load
         always_ff @(posedge clk) begin
            if (out_load) begin
               out_q <= use_skid_q ? skid_q : in_beat;
            end
            if (!out_load && up_fire) begin
               skid_q <= in_beat;
            end
         end
      end else begin : g_simple
         // --------------------------------------------------
         // Simple register with bubble
         // --------------------------------------------------
         always_ff @(posedge clk) begin
            if (!rst_n) begin
               ready_q     <= 1'b0;
               out_valid_q <= 1'b0;
            end else if (up_fire) begin
               ready_q     <= 1'b0;
               out_valid_q <= 1'b1;
            end else if (!ready_q && out_load) begin
               ready_q     <= 1'b1;
               out_valid_q <= 1'b0;
            end
         end

         always_ff @(posedge clk) begin
            if (up_fire) begin
               out_q <= in_beat;
            end
         end
      end
   endgenerate

   a_down_stable: assert property (@(posedge clk) disable iff (!rst_n)
      down.valid && !down.ready |=> down.valid && $stable(out_q));
   // Handshake outputs are always known once out of reset
   a_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(down.valid) && !$isunknown(up.ready));

   assign up.ready   = ready_q;
   assign down.valid = out_valid_q;
   assign down.id    = out_q.id;
   assign down.data  = out_q.data;
   assign down.resp  = out_q.resp;
   assign down.last  = out_q.last;

endmodule

/* hw/axi_ar_slice.sv */
/*
 * Read-address channel register slice
 * Skid mode: registered ready, output register plus one holding register
 * Simple mode: single output register, bubble cycle after each beat
 */
`timescale 1ns/100ps

module axi_ar_slice #(
   parameter slice_cfg_pkg::slice_mode_e MODE = slice_cfg_pkg::SLICE_SKID,
   parameter int ID_W   = slice_cfg_pkg::DEF_ID_W,
   parameter int ADDR_W = slice_cfg_pkg::DEF_ADDR_W
) (
   input  logic   clk,
   input  logic   rst_n,
   axi_ar_if.up   up,
   axi_ar_if.down down
);

   typedef struct packed {
      logic [ID_W-1:0]            id;
      logic [ADDR_W-1:0]          addr;
      axi_proto_pkg::axi_len_t    len;
      axi_proto_pkg::axi_size_t   size;
      axi_proto_pkg::axi_burst_e  burst;
      logic                       lock;
      axi_proto_pkg::axi_cache_t  cache;
      axi_proto_pkg::axi_prot_t   prot;
      axi_proto_pkg::axi_qos_t    qos;
      axi_proto_pkg::axi_region_t region;
   } ar_beat_t;

   ar_beat_t in_beat;
   ar_beat_t out_q;
   logic     out_valid_q;
   logic     ready_q;
   logic     up_fire;
   logic     out_load;

   assign in_beat = '{id: up.id, addr: up.addr, len: up.len, size: up.size,
                      burst: up.burst, lock: up.lock, cache: up.cache, prot: up.prot,
                      qos: up.qos, region: up.region};

   assign up_fire  = up.valid && ready_q;
   // Output register can take a beat when empty or drained this cycle
   assign out_load = !out_valid_q || down.ready;

   generate
      if (MODE == slice_cfg_pkg::SLICE_SKID) begin : g_skid
         // --------------------------------------------------
         // Skid buffer
         // --------------------------------------------------
         ar_beat_t skid_q;
         logic     use_skid_q;
         logic     use_skid_d;

         // Skid fills on an accepted beat while stalled, empties on next load
         always_comb begin
            use_skid_d = use_skid_q;
            if (out_load) begin
               use_skid_d = 1'b0;
            end else if (up_fire) begin
               use_skid_d = 1'b1;
            end
         end

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               out_valid_q <= 1'b0;
               use_skid_q  <= 1'b0;
               ready_q     <= 1'b0;
            end else begin
               use_skid_q <= use_skid_d;
               // Ready only while the holding register is free
               ready_q    <= !use_skid_d;
               if (out_load) begin
                  out_valid_q <= use_skid_q || up_fire;
               end
            end
         end

         always_ff @(posedge clk) begin
            if (out_load) begin
               out_q <= use_skid_q ? skid_q : in_beat;
            end
            if (!out_load && up_fire) begin
               skid_q <= in_beat;
            end
         end
      end else begin : g_simple
         // --------------------------------------------------
         // Simple register, ready and valid toggle
         // --------------------------------------------------
         always_ff @(posedge clk) begin
            if (!rst_n) begin
               ready_q     <= 1'b0;
               out_valid_q <= 1'b0;
            end else if (up_fire) begin
               ready_q     <= 1'b0;
               out_valid_q <= 1'b1;
            end else if (!ready_q && out_load) begin
               ready_q     <= 1'b1;
               out_valid_q <= 1'b0;
            end
         end

         always_ff @(posedge clk) begin
            if (up_fire) begin
               out_q <= in_beat;
            end
         end
      end
   endgenerate

   // Stalled beat held unchanged until the sink takes it
   a_down_stable: assert property (@(posedge clk) disable iff (!rst_n)
      down.valid && !down.ready |=> down.valid && $stable(out_q));
   // Source keeps a refused beat offered and unchanged until it is taken
   a_up_hold: assert property (@(posedge clk) disable iff (!rst_n)
      up.valid && !up.ready |=> up.valid && $stable(in_beat));

   assign up.ready    = ready_q;
   assign down.valid  = out_valid_q;
   assign down.id     = out_q.id;
   assign down.addr   = out_q.addr;
   assign down.len    = out_q.len;
   assign down.size   = out_q.size;
   assign down.burst  = out_q.burst;
   assign down.lock   = out_q.lock;
   assign down.cache  = out_q.cache;
   assign down.prot   = out_q.prot;
   assign down.qos    = out_q.qos;
   assign down.region = out_q.region;

endmodule

/* hw/axi_r_if.sv */
/*
 * AXI read-data channel bundle
 * Modport up faces the source side, modport down the sink side
 */
`timescale 1ns/100ps

interface axi_r_if #(
   parameter int ID_W   = slice_cfg_pkg::DEF_ID_W,
   parameter int DATA_W = slice_cfg_pkg::DEF_DATA_W
);
   // Handshake
   logic                     valid;
   logic                     ready;
   // Payload, last travels with the beat
   logic [ID_W-1:0]          id;
   logic [DATA_W-1:0]        data;
   axi_proto_pkg::axi_resp_e resp;
   logic                     last;

   // Slice input side
   modport up (input valid, id, data, resp, last, output ready);
   // Slice output side
   modport down (output valid, id, data, resp, last, input ready);

endinterface

/* hw/axi_ar_if.sv */
/*
 * AXI read-address channel bundle
 * Modport up faces the source side, modport down the sink side
 */
`timescale 1ns/100ps

interface axi_ar_if #(
   parameter int ID_W   = slice_cfg_pkg::DEF_ID_W,
   parameter int ADDR_W = slice_cfg_pkg::DEF_ADDR_W
);
   // Handshake
   logic                      valid;
   logic                      ready;
   // Payload
   logic [ID_W-1:0]           id;
   logic [ADDR_W-1:0]         addr;
   axi_proto_pkg::axi_len_t    len;
   axi_proto_pkg::axi_size_t   size;
   axi_proto_pkg::axi_burst_e  burst;
   logic                      lock;
   axi_proto_pkg::axi_cache_t  cache;
   axi_proto_pkg::axi_prot_t   prot;
   axi_proto_pkg::axi_qos_t    qos;
   axi_proto_pkg::axi_region_t region;

   // Slice input side
   modport up (input valid, id, addr, len, size, burst, lock, cache, prot, qos, region,
               output ready);
   // Slice output side
   modport down (output valid, id, addr, len, size, burst, lock, cache, prot, qos, region,
                 input ready);
endinterface

/* hw/slice_cfg_pkg.sv */
/*
 * Register slice configuration
 * Register mode selector and default channel widths
 */
package slice_cfg_pkg;

   // Skid gives full throughput, simple adds a bubble after each beat
   typedef enum logic {
      SLICE_SKID   = 1'b0,
      SLICE_SIMPLE = 1'b1
   } slice_mode_e;

   // --------------------------------------------------
   // Default widths
   // --------------------------------------------------
   localparam int DEF_ID_W   = 10;
   localparam int DEF_ADDR_W = 20;
   localparam int DEF_DATA_W = 64;

endpackage

/* hw/axi_proto_pkg.sv */
/*
 * AXI read channel field types
 * Burst and response opcodes as enums, attribute fields as typedefs
 */
package axi_proto_pkg;

   // Burst length minus one
   typedef logic [7:0] axi_len_t;
   // Bytes per beat, log2 encoded
   typedef logic [2:0] axi_size_t;
   // Cache, protection, QoS and region attributes
   typedef logic [3:0] axi_cache_t;
   typedef logic [2:0] axi_prot_t;
   typedef logic [3:0] axi_qos_t;
   typedef logic [3:0] axi_region_t;

   // Burst type, 2'b11 is reserved on the bus
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // Read response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

endpackage
